/* list.f */
displayPkg.sv
vgaTiming.sv
ballMotion.sv
sinCosTable.sv
colorMapper.sv
ballDisplay.sv
tbChecker.sv
tbBallDisplay.sv

/* run.sh */
#!/bin/sh
# build the ball display testbench with Verilator, run it and judge the output

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/100ps --top-module tbBallDisplay -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VtbBallDisplay)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* tbBallDisplay.sv */
// testbench top with clock, reset, frame-by-frame stimulus and watchdog around the ball display
module tbBallDisplay
    import displayPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // tiny raster so a frame is only a few thousand cycles
    localparam int hActive = 64;
    localparam int hFront  = 2;
    localparam int hSync   = 4;
    localparam int hBack   = 2;
    localparam int vActive = 48;
    localparam int vFront  = 2;
    localparam int vSync   = 4;
    localparam int vBack   = 2;
    localparam int frameCycles = (hActive + hFront + hSync + hBack) *
                                 (vActive + vFront + vSync + vBack);
    localparam int totalFrames = 2 + 6 + 50 + 20 + 10;
    // every test frame plus a few spare frames for reset and slack
    localparam int watchdogNs  = (totalFrames + 4) * frameCycles * 40;

    logic              clk;
    logic              reset;
    logic              run;
    logic [coordW-1:0] ballSize;
    rgbT               rgb;
    pixelT             pixelOut;
    logic              hSyncN;
    logic              vSyncN;
    int                errorCount;
    int                checkCount;

    always #20 clk = ~clk;

    ballDisplay #(
        .hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack),
        .ball1X0(16), .ball1Y0(12), .ball2X0(40), .ball2Y0(30)
    ) i_ballDisplay (
        .clk(clk), .reset(reset), .run(run), .ballSize(ballSize),
        .rgb(rgb), .pixelOut(pixelOut), .hSyncN(hSyncN), .vSyncN(vSyncN)
    );

    tbChecker #(
        .hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack),
        .ball1X0(16), .ball1Y0(12), .ball2X0(40), .ball2Y0(30)
    ) i_tbChecker (
        .clk(clk), .reset(reset), .run(run), .ballSize(ballSize), .rgb(rgb),
        .pixelOut(pixelOut), .hSyncN(hSyncN), .vSyncN(vSyncN),
        .errorCount(errorCount), .checkCount(checkCount)
    );

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------

    // returns 2 ns after the edge that shows the first blank line at the output
    task automatic waitFrameEnd();
        logic found;
        found = 1'b0;
        while (!found)
        begin
            @(posedge clk);
            #2;
            found = (int'(pixelOut.x) == 0) && (int'(pixelOut.y) == vActive);
        end
    endtask

    // size 0 picks a new random size in every vertical blanking
    task automatic runTest(input string name, input int frames, input logic runLevel,
                           input int size);
        int errBefore;
        int chkBefore;
        errBefore = errorCount;
        chkBefore = checkCount;
        run       = runLevel;
        if (size > 0)
        begin
            ballSize = coordW'(size);
        end
        for (int f = 0; f < frames; f++)
        begin
            if (size == 0)
            begin
                ballSize = coordW'($urandom % 7 + 2);
            end
            waitFrameEnd();
        end
        $display("test %-18s %3d frames, %7d checks, %0d errors", name, frames,
                 checkCount - chkBefore, errorCount - errBefore);
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial
    begin
        int seedValue;
        seedValue = $urandom(32'hfad4);
        clk       = 1'b0;
        reset     = 1'b1;
        run       = 1'b0;
        ballSize  = coordW'(4);
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        // blanking and sync widths are checked on every frame of every test
        runTest("static image", 2, 1'b0, 4);
        runTest("moving balls", 6, 1'b1, 4);
        runTest("edge bounce", 50, 1'b1, 4);
        runTest("rotation size 8", 20, 1'b1, 8);
        runTest("random size", 10, 1'b1, 0);
        $display("total %0d frames, %0d checks, %0d errors", totalFrames, checkCount,
                 errorCount);
        if (errorCount == 0 && checkCount > 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // stalled raster or a lost frame end stops here
    initial
    begin
        #(watchdogNs);
        $display("timeout: frame sequence did not finish within %0d ns", watchdogNs);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* tbChecker.sv */
// testbench checker that models raster, motion, angle and colouring and compares each DUT pixel
module tbChecker
    import displayPkg::*;
#(
    parameter int hActive = 64,
    parameter int hFront  = 2,
    parameter int hSync   = 4,
    parameter int hBack   = 2,
    parameter int vActive = 48,
    parameter int vFront  = 2,
    parameter int vSync   = 4,
    parameter int vBack   = 2,
    parameter int ball1X0 = 16,
    parameter int ball1Y0 = 12,
    parameter int ball2X0 = 40,
    parameter int ball2Y0 = 30
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    input  logic [coordW-1:0] ballSize,
    input  rgbT               rgb,
    input  pixelT             pixelOut,
    input  logic              hSyncN,
    input  logic              vSyncN,
    output int                errorCount,
    output int                checkCount
);
    timeunit 1ns;
    timeprecision 100ps;

    // full raster including blanking
    localparam int hTotal = hActive + hFront + hSync + hBack;
    localparam int vTotal = vActive + vFront + vSync + vBack;

    // model state with ball centres, directions and angle
    int   b1x;
    int   b1y;
    int   b2x;
    int   b2y;
    logic b1xNeg;
    logic b1yNeg;
    logic b2xNeg;
    logic b2yNeg;
    int   angle;
    // raster position the next output pixel should carry
    int   expX;
    int   expY;
    // inputs as the DUT saw them at the last rising edge
    logic prevReset;
    logic prevRun;
    int   prevSize;
    int   sineTab [64];

    // sine table from 127 sin(2 pi k / 64) rounded to nearest
    initial
    begin
        real v;
        for (int k = 0; k < 64; k++)
        begin
            v = 127.0 * $sin(2.0 * 3.14159265358979 * k / 64.0);
            sineTab[k] = (v >= 0.0) ? $rtoi(v + 0.5) : $rtoi(v - 0.5);
        end
        prevReset  = 1'b1;
        expX       = 0;
        expY       = 0;
        errorCount = 0;
        checkCount = 0;
    end

    // ------------------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------------------

    // direction after the edge test on one axis
    function automatic logic newDir(int pos, logic neg, int size, int extent);
        if (neg)
        begin
            return !(pos <= size);
        end
        return (pos + size >= extent - 1);
    endfunction

    function automatic rgbT expectedColor(int px, int py, logic on, int size);
        int dx;
        int dy;
        int rx;
        int ry;
        int sn;
        int cs;
        if (!on)
        begin
            return blankColor;
        end
        dx = px - b1x;
        dy = py - b1y;
        // ball 1 wins wherever both squares cover the pixel
        if ((dx < 0 ? -dx : dx) <= size && (dy < 0 ? -dy : dy) <= size)
        begin
            return ball1Color;
        end
        sn = sineTab[angle];
        cs = sineTab[(angle + 16) % 64];
        dx = px - b2x;
        dy = py - b2y;
        rx = (dx * cs + dy * sn) >>> 7;
        ry = (dy * cs - dx * sn) >>> 7;
        if ((rx < 0 ? -rx : rx) <= size && (ry < 0 ? -ry : ry) <= size)
        begin
            return ball2Color;
        end
        return backColor;
    endfunction

    task automatic compareValue(string name, int px, int py, logic [23:0] expected,
                                logic [23:0] got);
        checkCount++;
        if (expected !== got)
        begin
            errorCount++;
            $display("FAIL %s at (%0d,%0d): expected %0h got %0h",
                     name, px, py, expected, got);
        end
    endtask

    // ------------------------------------------------------------------------
    // compare at the falling edge where every DUT output is settled
    // ------------------------------------------------------------------------
    always @(negedge clk)
    begin
        logic expOn;
        logic expH;
        logic expV;
        expOn = (expX < hActive) && (expY < vActive);
        expH  = !(expX >= hActive + hFront && expX < hActive + hFront + hSync);
        expV  = !(expY >= vActive + vFront && expY < vActive + vFront + vSync);
        if (prevReset !== 1'b0)
        begin
            // outputs still hold reset values so only the model restarts
            b1x    = ball1X0;
            b1y    = ball1Y0;
            b2x    = ball2X0;
            b2y    = ball2Y0;
            b1xNeg = 1'b0;
            b1yNeg = 1'b0;
            b2xNeg = 1'b1;
            b2yNeg = 1'b1;
            angle  = 0;
            expX   = 0;
            expY   = 0;
        end
        else
        begin
            compareValue("pixelOut.x", expX, expY, 24'(expX), 24'(pixelOut.x));
            compareValue("pixelOut.y", expX, expY, 24'(expY), 24'(pixelOut.y));
            compareValue("displayOn", expX, expY, {23'b0, expOn}, {23'b0, pixelOut.displayOn});
            compareValue("hSyncN", expX, expY, {23'b0, expH}, {23'b0, hSyncN});
            compareValue("vSyncN", expX, expY, {23'b0, expV}, {23'b0, vSyncN});
            compareValue("rgb", expX, expY, expectedColor(expX, expY, expOn, prevSize), rgb);
            // this pixel used the old state and the next one sees the step
            if (expX == 0 && expY == vActive && prevRun)
            begin
                b1xNeg = newDir(b1x, b1xNeg, prevSize, hActive);
                b1x    = b1xNeg ? b1x - 1 : b1x + 1;
                b1yNeg = newDir(b1y, b1yNeg, prevSize, vActive);
                b1y    = b1yNeg ? b1y - 1 : b1y + 1;
                b2xNeg = newDir(b2x, b2xNeg, prevSize, hActive);
                b2x    = b2xNeg ? b2x - 1 : b2x + 1;
                b2yNeg = newDir(b2y, b2yNeg, prevSize, vActive);
                b2y    = b2yNeg ? b2y - 1 : b2y + 1;
                angle  = (angle + 1) % 64;
            end
            // raster scans left to right and then top to bottom
            if (expX == hTotal - 1)
            begin
                expX = 0;
                expY = (expY + 1) % vTotal;
            end
            else
            begin
                expX = expX + 1;
            end
        end
        prevReset = reset;
        prevRun   = run;
        prevSize  = int'(ballSize);
    end

endmodule

/* ballDisplay.sv */
// display top level joining raster timing, ball motion, rotation angle and colour mapping
module ballDisplay
    import displayPkg::*;
#(
    parameter int hActive = 640,
    parameter int hFront  = 16,
    parameter int hSync   = 96,
    parameter int hBack   = 48,
    parameter int vActive = 480,
    parameter int vFront  = 10,
    parameter int vSync   = 2,
    parameter int vBack   = 33,
    parameter int ball1X0 = 320,
    parameter int ball1Y0 = 240,
    parameter int ball2X0 = 200,
    parameter int ball2Y0 = 150
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    input  logic [coordW-1:0] ballSize,
    output rgbT               rgb,
    output pixelT             pixelOut,
    output logic              hSyncN,
    output logic              vSyncN
);

    // raster position and syncs before the colour stage
    pixelT pixel;
    logic  hSyncRaw;
    logic  vSyncRaw;
    logic  frameTick;
    ballT  ball1;
    ballT  ball2;
    trigT  trig;

    vgaTiming #(
        .hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
        .vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
    ) i_vgaTiming (
        .clk(clk), .reset(reset), .pixel(pixel),
        .hSyncN(hSyncRaw), .vSyncN(vSyncRaw), .frameTick(frameTick)
    );

    // motion only needs the visible extent for its bounce test
    ballMotion #(
        .hActive(hActive), .vActive(vActive),
        .ball1X0(ball1X0), .ball1Y0(ball1Y0), .ball2X0(ball2X0), .ball2Y0(ball2Y0)
    ) i_ballMotion (
        .clk(clk), .reset(reset), .frameTick(frameTick), .run(run),
        .ballSize(ballSize), .ball1(ball1), .ball2(ball2)
    );

    sinCosTable i_sinCosTable (
        .clk(clk), .reset(reset), .frameTick(frameTick), .run(run), .trig(trig)
    );

    colorMapper i_colorMapper (
        .clk(clk), .reset(reset), .pixel(pixel), .hSyncIn(hSyncRaw), .vSyncIn(vSyncRaw),
        .ball1(ball1), .ball2(ball2), .trig(trig), .ballSize(ballSize),
        .rgb(rgb), .pixelOut(pixelOut), .hSyncN(hSyncN), .vSyncN(vSyncN)
    );

endmodule

/* colorMapper.sv */
// per-pixel colour from both ball hit tests, registered with the pixel and syncs
module colorMapper
    import displayPkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  pixelT             pixel,
    input  logic              hSyncIn,
    input  logic              vSyncIn,
    input  ballT              ball1,
    input  ballT              ball2,
    input  trigT              trig,
    input  logic [coordW-1:0] ballSize,
    output rgbT               rgb,
    output pixelT             pixelOut,
    output logic              hSyncN,
    output logic              vSyncN
);

    // offsets carry one sign bit above the coordinate
    localparam int offW  = coordW + 1;
    // product of an offset and an 8-bit coefficient
    localparam int prodW = offW + 8;
    // sum of two products
    localparam int sumW  = prodW + 1;

    logic signed [offW-1:0]  sizeS;
    logic signed [offW-1:0]  dx1;
    logic signed [offW-1:0]  dy1;
    logic signed [offW-1:0]  dx2;
    logic signed [offW-1:0]  dy2;
    logic signed [7:0]       sinV;
    logic signed [7:0]       cosV;
    logic signed [prodW-1:0] dxCos;
    logic signed [prodW-1:0] dySin;
    logic signed [prodW-1:0] dyCos;
    logic signed [prodW-1:0] dxSin;
    logic signed [sumW-1:0]  rx;
    logic signed [sumW-1:0]  ry;
    logic signed [sumW-1:0]  absRx;
    logic signed [sumW-1:0]  absRy;
    logic signed [sumW-1:0]  sizeWide;
    logic                    ball1On;
    logic                    ball2On;
    rgbT                     rgbNext;

    // ------------------------------------------------------------------------
    // ball 1 is a plain square around its centre
    // ------------------------------------------------------------------------
    always_comb
    begin
        sizeS   = $signed({1'b0, ballSize});
        dx1     = $signed({1'b0, pixel.x}) - $signed({1'b0, ball1.x});
        dy1     = $signed({1'b0, pixel.y}) - $signed({1'b0, ball1.y});
        ball1On = (dx1 >= -sizeS) && (dx1 <= sizeS) && (dy1 >= -sizeS) && (dy1 <= sizeS);
    end

    // ------------------------------------------------------------------------
    // ball 2 offset rotated back into the square's own frame
    // ------------------------------------------------------------------------
    always_comb
    begin
        sinV  = trig.sin;
        cosV  = trig.cos;
        dx2   = $signed({1'b0, pixel.x}) - $signed({1'b0, ball2.x});
        dy2   = $signed({1'b0, pixel.y}) - $signed({1'b0, ball2.y});
        // both operands sign-extended to the product width
        dxCos = prodW'(dx2) * prodW'(cosV);
        dySin = prodW'(dy2) * prodW'(sinV);
        dyCos = prodW'(dy2) * prodW'(cosV);
        dxSin = prodW'(dx2) * prodW'(sinV);
        // drop the 127 scale while the shift keeps the sign
        rx    = (sumW'(dxCos) + sumW'(dySin)) >>> 7;
        ry    = (sumW'(dyCos) - sumW'(dxSin)) >>> 7;
        absRx = rx[sumW-1] ? -rx : rx;
        absRy = ry[sumW-1] ? -ry : ry;
        sizeWide = $signed({{(sumW - coordW){1'b0}}, ballSize});
        ball2On  = (absRx <= sizeWide) && (absRy <= sizeWide);
    end

    // ------------------------------------------------------------------------
    // priority puts blanking first then ball 1 over ball 2
    // ------------------------------------------------------------------------
    always_comb
    begin
        if (!pixel.displayOn)
        begin
            rgbNext = blankColor;
        end
        else if (ball1On)
        begin
            rgbNext = ball1Color;
        end
        else if (ball2On)
        begin
            rgbNext = ball2Color;
        end
        else
        begin
            rgbNext = backColor;
        end
    end

    // colour, position and syncs leave together
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rgb      <= blankColor;
            pixelOut <= '0;
            hSyncN   <= 1'b1;
            vSyncN   <= 1'b1;
        end
        else
        begin
            rgb      <= rgbNext;
            pixelOut <= pixel;
            hSyncN   <= hSyncIn;
            vSyncN   <= vSyncIn;
        end
    end

endmodule

/* sinCosTable.sv */
// frame-stepped angle and its sine and cosine coefficients for the rotating ball
module sinCosTable
    import displayPkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic frameTick,
    input  logic run,
    output trigT trig
);

    localparam int steps = 2 ** angleW;
    // cosine leads sine by a quarter turn in angle steps
    localparam logic [angleW-1:0] quarter = angleW'(steps / 4);

    typedef logic signed [7:0] sineTableT [steps];

    // ------------------------------------------------------------------------
    // table built at elaboration as round(127 * sin(2 pi k / 64))
    // ------------------------------------------------------------------------
    function automatic sineTableT buildSine();
        sineTableT values;
        real       phase;
        for (int k = 0; k < steps; k++)
        begin
            phase     = 2.0 * 3.141592653589793 * real'(k) / real'(steps);
            // int cast rounds to nearest
            values[k] = 8'(int'(127.0 * $sin(phase)));
        end
        return values;
    endfunction

    localparam sineTableT sineRom = buildSine();

    logic [angleW-1:0] angle;
    logic [angleW-1:0] cosIndex;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            angle <= '0;
        end
        else if (frameTick && run)
        begin
            // wraps naturally at 64
            angle <= angle + 1'b1;
        end
    end

    // second read of the same table shifted by a quarter turn
    assign cosIndex = angle + quarter;

    assign trig.sin = sineRom[angle];
    assign trig.cos = sineRom[cosIndex];

endmodule

/* ballMotion.sv */
// two bouncing ball positions, stepped once per frame while run is high
module ballMotion
    import displayPkg::*;
#(
    parameter int hActive = 640,
    parameter int vActive = 480,
    parameter int ball1X0 = 320,
    parameter int ball1Y0 = 240,
    parameter int ball2X0 = 200,
    parameter int ball2Y0 = 150
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              frameTick,
    input  logic              run,
    input  logic [coordW-1:0] ballSize,
    output ballT              ball1,
    output ballT              ball2
);

    // last coordinate of the visible area on each axis
    localparam logic [coordW:0] hLimit = (coordW + 1)'(hActive - 1);
    localparam logic [coordW:0] vLimit = (coordW + 1)'(vActive - 1);

    // ------------------------------------------------------------------------
    // per-axis step and bounce returning {direction, position}
    // ------------------------------------------------------------------------
    function automatic logic [coordW:0] stepAxis(
        input logic [coordW-1:0] pos,
        input logic              neg,
        input logic [coordW-1:0] size,
        input logic [coordW:0]   limit
    );
        logic [coordW:0]   reach;
        logic              flip;
        logic              newNeg;
        logic [coordW-1:0] newPos;
        // far edge of the square with one extra bit so it cannot wrap
        reach = {1'b0, pos} + {1'b0, size};
        if (neg)
        begin
            flip = (pos <= size);
        end
        else
        begin
            flip = (reach >= limit);
        end
        newNeg = neg ^ flip;
        // move after the turn so the ball never overshoots the edge
        newPos = newNeg ? pos - 1'b1 : pos + 1'b1;
        return {newNeg, newPos};
    endfunction

    // both axes of one ball
    function automatic ballT stepBall(input ballT b, input logic [coordW-1:0] size);
        logic [coordW:0] xs;
        logic [coordW:0] ys;
        xs = stepAxis(b.x, b.xNeg, size, hLimit);
        ys = stepAxis(b.y, b.yNeg, size, vLimit);
        return '{x: xs[coordW-1:0], y: ys[coordW-1:0], xNeg: xs[coordW], yNeg: ys[coordW]};
    endfunction

    // ------------------------------------------------------------------------
    // state registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // ball 1 heads down and right
            ball1 <= '{x: coordW'(ball1X0), y: coordW'(ball1Y0), xNeg: 1'b0, yNeg: 1'b0};
            // ball 2 heads up and left
            ball2 <= '{x: coordW'(ball2X0), y: coordW'(ball2Y0), xNeg: 1'b1, yNeg: 1'b1};
        end
        else if (frameTick && run)
        begin
            // tick sits in vertical blanking so no frame sees a half update
            ball1 <= stepBall(ball1, ballSize);
            ball2 <= stepBall(ball2, ballSize);
        end
    end

endmodule

/* vgaTiming.sv */
// raster generator giving pixel position, active flag, sync pulses and a frame pulse
module vgaTiming
    import displayPkg::*;
#(
    parameter int hActive = 640,
    parameter int hFront  = 16,
    parameter int hSync   = 96,
    parameter int hBack   = 48,
    parameter int vActive = 480,
    parameter int vFront  = 10,
    parameter int vSync   = 2,
    parameter int vBack   = 33
)
(
    input  logic  clk,
    input  logic  reset,
    output pixelT pixel,
    output logic  hSyncN,
    output logic  vSyncN,
    output logic  frameTick
);

    // full line and frame lengths including blanking
    localparam int hTotal     = hActive + hFront + hSync + hBack;
    localparam int vTotal     = vActive + vFront + vSync + vBack;
    localparam int hSyncStart = hActive + hFront;
    localparam int vSyncStart = vActive + vFront;

    logic [coordW-1:0] hCount;
    logic [coordW-1:0] vCount;
    logic [coordW-1:0] hNext;
    logic [coordW-1:0] vNext;
    logic              lineEnd;
    logic              displayOn;
    logic              onNext;
    logic              hSyncNext;
    logic              vSyncNext;
    logic              tickNext;

    // ------------------------------------------------------------------------
    // counter stepping
    // ------------------------------------------------------------------------
    always_comb
    begin
        lineEnd = (hCount == coordW'(hTotal - 1));
        hNext   = lineEnd ? '0 : hCount + 1'b1;
        // vertical counter only moves at the end of a line
        if (!lineEnd)
        begin
            vNext = vCount;
        end
        else if (vCount == coordW'(vTotal - 1))
        begin
            vNext = '0;
        end
        else
        begin
            vNext = vCount + 1'b1;
        end
        // decode from the next position so flags line up with the counters
        onNext    = (hNext < coordW'(hActive)) && (vNext < coordW'(vActive));
        hSyncNext = !((hNext >= coordW'(hSyncStart)) &&
                      (hNext < coordW'(hSyncStart + hSync)));
        vSyncNext = !((vNext >= coordW'(vSyncStart)) &&
                      (vNext < coordW'(vSyncStart + vSync)));
        // first pixel of the first blank line
        tickNext  = (hNext == '0) && (vNext == coordW'(vActive));
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hCount    <= '0;
            vCount    <= '0;
            displayOn <= 1'b1;
            hSyncN    <= 1'b1;
            vSyncN    <= 1'b1;
            frameTick <= 1'b0;
        end
        else
        begin
            hCount    <= hNext;
            vCount    <= vNext;
            displayOn <= onNext;
            hSyncN    <= hSyncNext;
            vSyncN    <= vSyncNext;
            frameTick <= tickNext;
        end
    end

    assign pixel = '{x: hCount, y: vCount, displayOn: displayOn};

endmodule

/* displayPkg.sv */
// shared display types and palette, imported by every module of the ball display
package displayPkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------

    // screen coordinate wide enough for a full 800 x 525 raster
    localparam int coordW = 10;

    // angle index with 64 steps per full turn
    localparam int angleW = 6;

    // ------------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------------

    // one raster position plus the active-area flag
    typedef struct packed {
        logic [coordW-1:0] x;
        logic [coordW-1:0] y;
        // high inside the visible area
        logic              displayOn;
    } pixelT;

    // 24-bit colour with one byte per channel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    // ball centre and direction of travel
    typedef struct packed {
        logic [coordW-1:0] x;
        logic [coordW-1:0] y;
        // set when moving toward smaller x
        logic              xNeg;
        // set when moving toward smaller y
        logic              yNeg;
    } ballT;

    // rotation coefficients scaled so that full scale is 127
    typedef struct packed {
        logic signed [7:0] sin;
        logic signed [7:0] cos;
    } trigT;

    // ------------------------------------------------------------------------
    // palette
    // ------------------------------------------------------------------------

    // orange for the plain square
    localparam rgbT ball1Color = '{red: 8'hff, green: 8'hbb, blue: 8'h00};
    // red for the rotating square
    localparam rgbT ball2Color = '{red: 8'hff, green: 8'h00, blue: 8'h00};
    // mid grey behind the balls
    localparam rgbT backColor  = '{red: 8'h55, green: 8'h55, blue: 8'h55};
    // outside the active area the monitor expects black
    localparam rgbT blankColor = '{red: 8'h00, green: 8'h00, blue: 8'h00};

endpackage
